//--- sources.f
verilog/fetch_pkg.sv
verilog/line_store.sv
verilog/prefetch_ctrl.sv
verilog/fetch_buffer.sv
verilog/pc_gen.sv
verilog/fetch_top.sv
verif/tb_clock.sv
verif/icache_model.sv
verif/fetch_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module fetch_tb -f sources.f -o fetch_sim
	./obj_dir/fetch_sim | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/fetch_tb.sv
`default_nettype none

module fetch_tb;

  // each stimulus mode adds to the one before
  localparam int MODE_QUIET    = 0;
  localparam int MODE_STALL    = 1;
  localparam int MODE_REDIRECT = 2;

  logic             clk;
  logic             rst_n;
  logic             redirect    = 1'b0;
  fetch_pkg::pc_t   redirect_pc = fetch_pkg::RESET_PC;
  logic             stall       = 1'b0;
  logic             ar_ready;
  logic             ar_valid;
  fetch_pkg::pc_t   ar_addr;
  logic             r_valid;
  fetch_pkg::line_t r_data;
  logic             r_ready;
  logic             inst_valid;
  fetch_pkg::inst_t inst;
  fetch_pkg::pc_t   pc;

  logic [31:0]      lfsr_state = 32'hab56_43fb;
  int               mode       = MODE_QUIET;
  int               valid_cnt  = 0;
  int               err_cnt    = 0;
  int               tests_run  = 0;
  int               tests_bad  = 0;
  logic             timed_out  = 1'b0;

  // reference model
  fetch_pkg::pc_t   exp_pc        = fetch_pkg::RESET_PC;
  fetch_pkg::pc_t   last_pc       = '0;
  fetch_pkg::pc_t   last_target   = '0;
  fetch_pkg::pc_t   last_ar_addr  = '0;
  logic             last_redirect = 1'b0;
  logic             last_hold     = 1'b0;
  logic             last_ar_wait  = 1'b0;
  logic             in_reset      = 1'b1;

  tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  icache_model u_icache (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_ready_i  (r_ready)
  );

  fetch_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .stall_i       (stall),
    .ar_ready_i    (ar_ready),
    .ar_valid_o    (ar_valid),
    .ar_addr_o     (ar_addr),
    .r_valid_i     (r_valid),
    .r_data_i      (r_data),
    .r_ready_o     (r_ready),
    .inst_valid_o  (inst_valid),
    .inst_o        (inst),
    .pc_o          (pc)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = {1'b0, s[31:1]};
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    $display("FAILED %s: got %h, expected %h", name, got, want);
    err_cnt++;
  endtask

  task automatic flag_problem(input string what);
    $display("error: %s", what);
    err_cnt++;
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================

  always @(posedge clk) begin : drive
    int pick;
    int offset;
    stall    <= 1'b0;
    redirect <= 1'b0;
    if (!rst_n) begin
      if (mode >= MODE_STALL) begin
        take_bits(2, pick);
        stall <= (pick == 0);
      end
      // redirects stay single-cycle pulses
      if (mode >= MODE_REDIRECT && !redirect) begin
        take_bits(4, pick);
        if (pick == 0) begin
          take_bits(10, offset);
          redirect    <= 1'b1;
          redirect_pc <= fetch_pkg::RESET_PC + fetch_pkg::pc_t'(offset * 4);
        end
      end
    end
  end

  // ==========================================================================
  // checks against the expected instruction stream
  // ==========================================================================

  always @(posedge clk) begin : check
    if (rst_n) begin
      exp_pc        <= fetch_pkg::RESET_PC;
      in_reset      <= 1'b1;
      last_redirect <= 1'b0;
      last_hold     <= 1'b0;
      last_ar_wait  <= 1'b0;
    end else begin
      if (in_reset) begin
        assert (!ar_valid && !r_ready && !inst_valid)
          else flag_problem("handshake outputs not idle after reset");
        assert (pc == fetch_pkg::RESET_PC)
          else flag_mismatch("pc_o", pc, fetch_pkg::RESET_PC);
      end
      if (inst_valid) begin
        assert (pc == exp_pc) else flag_mismatch("pc_o", pc, exp_pc);
        assert (inst == exp_pc) else flag_mismatch("inst_o", inst, exp_pc);
        valid_cnt <= valid_cnt + 1;
      end
      // pc one cycle after a redirect or a stall
      if (last_redirect) begin
        assert (pc == last_target) else flag_mismatch("pc_o", pc, last_target);
      end else if (last_hold) begin
        assert (pc == last_pc) else flag_mismatch("pc_o", pc, last_pc);
      end
      if (ar_valid) begin
        assert (ar_addr[3:0] == 4'h0)
          else flag_mismatch("ar_addr_o", ar_addr, {ar_addr[31:4], 4'h0});
      end
      if (last_ar_wait) begin
        assert (ar_valid) else flag_problem("ar_valid_o dropped before ar_ready_i");
        assert (ar_addr == last_ar_addr)
          else flag_mismatch("ar_addr_o", ar_addr, last_ar_addr);
      end
      if (redirect) begin
        exp_pc <= redirect_pc;
      end else if (inst_valid && !stall) begin
        exp_pc <= exp_pc + fetch_pkg::pc_t'(4);
      end
      in_reset      <= 1'b0;
      last_redirect <= redirect;
      last_target   <= redirect_pc;
      last_hold     <= stall && !redirect;
      last_pc       <= pc;
      last_ar_wait  <= ar_valid && !ar_ready;
      last_ar_addr  <= ar_addr;
    end
  end

  // runs until enough instructions were delivered
  task automatic run_test(input string name, input int test_mode, input int needed);
    int start_valid;
    int start_err;
    int cycles;
    int limit;
    if (!timed_out) begin
      @(negedge clk);
      mode        = test_mode;
      start_valid = valid_cnt;
      start_err   = err_cnt;
      cycles      = 0;
      limit       = 40 * needed + 200;
      while (valid_cnt - start_valid < needed && cycles < limit) begin
        @(negedge clk);
        cycles++;
      end
      tests_run++;
      if (valid_cnt - start_valid < needed) begin
        $display("timeout in test %s: %0d of %0d instructions after %0d cycles",
                 name, valid_cnt - start_valid, needed, cycles);
        timed_out = 1'b1;
        tests_bad++;
      end else begin
        if (err_cnt != start_err) begin
          tests_bad++;
        end
        $display("test %s: %0d instructions, %0d errors", name, needed,
                 err_cnt - start_err);
      end
    end
  endtask

  initial begin : run
    int waited;
    waited = 0;
    while (rst_n && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n) begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
    end
    run_test("reset", MODE_QUIET, 1);
    run_test("sequential", MODE_QUIET, 40);
    run_test("stall", MODE_STALL, 40);
    run_test("redirect", MODE_REDIRECT, 60);
    run_test("backpressure", MODE_REDIRECT, 200);
    $display("%0d tests run, %0d failed, %0d check errors, %0d instructions",
             tests_run, tests_bad, err_cnt, valid_cnt);
    if (timed_out || err_cnt != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/icache_model.sv
`default_nettype none

module icache_model (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ar_valid_i,
  input  fetch_pkg::pc_t    ar_addr_i,
  output logic              ar_ready_o,
  output logic              r_valid_o,
  output fetch_pkg::line_t  r_data_o,
  input  logic              r_ready_i
);

  logic [31:0]      lfsr_state = 32'hab56_43fb;
  logic             ar_ready_q = 1'b0;
  logic             r_valid_q  = 1'b0;
  fetch_pkg::line_t r_data_q   = '0;
  // address taken, line not yet accepted
  logic             busy       = 1'b0;
  int               wait_cnt   = 0;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = {1'b0, s[31:1]};
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // every word holds its own byte address
  function automatic fetch_pkg::line_t line_at(input fetch_pkg::pc_t addr);
    fetch_pkg::line_t l;
    fetch_pkg::pc_t   base;
    base = {addr[31:4], 4'h0};
    for (int w = 0; w < 4; w++) begin
      l[w*32 +: 32] = base + fetch_pkg::pc_t'(4 * w);
    end
    return l;
  endfunction

  // ==========================================================================
  // one request at a time, 0 to 3 idle cycles before each ready and valid
  // ==========================================================================

  always @(posedge clk) begin : respond
    int d;
    if (rst_n) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      busy       = 1'b0;
      wait_cnt   = 0;
    end else if (!busy) begin
      if (ar_valid_i && ar_ready_q) begin
        ar_ready_q <= 1'b0;
        r_data_q   <= line_at(ar_addr_i);
        busy       = 1'b1;
        take_bits(2, d);
        wait_cnt   = d;
      end else if (ar_valid_i) begin
        if (wait_cnt == 0) begin
          ar_ready_q <= 1'b1;
        end else begin
          wait_cnt--;
        end
      end
    end else begin
      if (r_valid_q && r_ready_i) begin
        r_valid_q <= 1'b0;
        busy      = 1'b0;
        take_bits(2, d);
        wait_cnt  = d;
      end else if (!r_valid_q) begin
        if (wait_cnt == 0) begin
          r_valid_q <= 1'b1;
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  assign ar_ready_o = ar_ready_q;
  assign r_valid_o  = r_valid_q;
  assign r_data_o   = r_data_q;

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 5;

  logic clk_q    = 1'b0;
  logic rst_q    = 1'b1;
  int   edge_cnt = 0;

  always #HALF_PERIOD clk_q = ~clk_q;

  // reset seen by the first five rising edges
  always @(posedge clk_q) begin
    if (edge_cnt < RESET_CYCLES) begin
      edge_cnt <= edge_cnt + 1;
    end
    rst_q <= (edge_cnt < RESET_CYCLES - 1);
  end

  assign clk_o   = clk_q;
  assign rst_n_o = rst_q;

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
`default_nettype none

module fetch_top (
  input  logic              clk,
  input  logic              rst_n,
  // core side control
  input  logic              redirect_i,
  input  fetch_pkg::pc_t    redirect_pc_i,
  input  logic              stall_i,
  // cache read port
  input  logic              ar_ready_i,
  output logic              ar_valid_o,
  output fetch_pkg::pc_t    ar_addr_o,
  input  logic              r_valid_i,
  input  fetch_pkg::line_t  r_data_i,
  output logic              r_ready_o,
  // to decode
  output logic              inst_valid_o,
  output fetch_pkg::inst_t  inst_o,
  output fetch_pkg::pc_t    pc_o
);

  fetch_pkg::pc_t fetch_pc;
  logic           flush;
  logic           inst_valid;

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .inst_valid_i  (inst_valid),
    .pc_o          (fetch_pc),
    .flush_o       (flush)
  );

  fetch_buffer u_fetch_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_pc_i   (fetch_pc),
    .flush_i      (flush),
    .ar_ready_i   (ar_ready_i),
    .ar_valid_o   (ar_valid_o),
    .ar_addr_o    (ar_addr_o),
    .r_valid_i    (r_valid_i),
    .r_data_i     (r_data_i),
    .r_ready_o    (r_ready_o),
    .inst_valid_o (inst_valid),
    .inst_o       (inst_o)
  );

  assign inst_valid_o = inst_valid;
  assign pc_o         = fetch_pc;

endmodule

`default_nettype wire

//--- verilog/pc_gen.sv
`default_nettype none

module pc_gen (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            redirect_i,
  input  fetch_pkg::pc_t  redirect_pc_i,
  input  logic            stall_i,
  input  logic            inst_valid_i,
  output fetch_pkg::pc_t  pc_o,
  output logic            flush_o
);

  fetch_pkg::pc_t pc_q;
  logic           flush_q;
  logic           advance;

  // instruction taken by decode
  // nothing is taken in the flush cycle of a redirect
  assign advance = inst_valid_i && !stall_i && !flush_q;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q    <= fetch_pkg::RESET_PC;
      flush_q <= 1'b0;
    end else begin
      flush_q <= redirect_i;
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (advance) begin
        pc_q <= pc_q + fetch_pkg::pc_t'(4);
      end
    end
  end

  assign pc_o    = pc_q;
  assign flush_o = flush_q;

  // redirect targets from decode must be word aligned as well
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst_n)
    pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verilog/fetch_buffer.sv
`default_nettype none

module fetch_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  fetch_pkg::pc_t    fetch_pc_i,
  input  logic              flush_i,
  input  logic              ar_ready_i,
  output logic              ar_valid_o,
  output fetch_pkg::pc_t    ar_addr_o,
  input  logic              r_valid_i,
  input  fetch_pkg::line_t  r_data_i,
  output logic              r_ready_o,
  output logic              inst_valid_o,
  output fetch_pkg::inst_t  inst_o
);

  fetch_pkg::ptr_t      wptr_q;
  fetch_pkg::ptr_t      rptr_q;
  fetch_pkg::ptr_t      count;
  fetch_pkg::line_tag_t head_tag_q;
  fetch_pkg::line_tag_t pc_tag;
  fetch_pkg::line_tag_t next_tag;
  fetch_pkg::line_t     head_line;
  fetch_pkg::pc_t       req_addr;
  logic                 fifo_full;
  logic                 fifo_empty;
  logic                 tag_hit;
  logic                 pop;
  logic                 line_we;

  // ==========================================================================
  // FIFO pointers
  // ==========================================================================

  assign fifo_empty = (wptr_q == rptr_q);
  assign fifo_full  = (wptr_q == {~rptr_q[2], rptr_q[1:0]});
  assign count      = wptr_q - rptr_q;

  assign pc_tag  = fetch_pc_i[31:4];
  assign tag_hit = (pc_tag == head_tag_q);
  // pc left the head line
  assign pop     = !fifo_empty && !tag_hit;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      head_tag_q <= fetch_pkg::RESET_PC[31:4];
    end else begin
      if (line_we) begin
        wptr_q <= wptr_q + fetch_pkg::ptr_t'(1);
      end
      if (flush_i) begin
        rptr_q <= wptr_q;
      end else if (pop) begin
        rptr_q <= rptr_q + fetch_pkg::ptr_t'(1);
      end
      // head tag trails the pc by one cycle, also after a flush
      head_tag_q <= pc_tag;
    end
  end

  // ==========================================================================
  // request address
  // ==========================================================================

  // first line past what is already buffered
  assign next_tag = head_tag_q + fetch_pkg::line_tag_t'(count);

  always_comb begin
    if (flush_i) begin
      req_addr = {pc_tag, 4'h0};
    end else begin
      req_addr = {next_tag, 4'h0};
    end
  end

  prefetch_ctrl u_prefetch_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .fifo_full_i (fifo_full),
    .flush_i     (flush_i),
    .req_addr_i  (req_addr),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .r_ready_o   (r_ready_o),
    .line_we_o   (line_we)
  );

  line_store u_line_store (
    .clk     (clk),
    .we_i    (line_we),
    .waddr_i (wptr_q[1:0]),
    .wdata_i (r_data_i),
    .raddr_i (rptr_q[1:0]),
    .rdata_o (head_line)
  );

  // ==========================================================================
  // instruction out
  // ==========================================================================

  // empty FIFO delivers through the line store bypass
  assign inst_valid_o = !flush_i && tag_hit && (!fifo_empty || line_we);

  always_comb begin
    case (fetch_pc_i[3:2])
      2'd0:    inst_o = head_line[31:0];
      2'd1:    inst_o = head_line[63:32];
      2'd2:    inst_o = head_line[95:64];
      default: inst_o = head_line[127:96];
    endcase
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (rst_n)
    line_we |-> !fifo_full);

endmodule

`default_nettype wire

//--- verilog/prefetch_ctrl.sv
`default_nettype none

module prefetch_ctrl (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            fifo_full_i,
  input  logic            flush_i,
  input  fetch_pkg::pc_t  req_addr_i,
  input  logic            ar_ready_i,
  input  logic            r_valid_i,
  output logic            ar_valid_o,
  output fetch_pkg::pc_t  ar_addr_o,
  output logic            r_ready_o,
  output logic            line_we_o
);

  fetch_pkg::req_state_t state_q;
  fetch_pkg::pc_t        ar_addr_q;
  logic                  ar_valid_q;
  logic                  stale_q;
  logic                  launch;
  logic                  ar_hs;
  logic                  r_hs;

  // ==========================================================================
  // handshakes
  // ==========================================================================

  assign launch = (state_q == fetch_pkg::REQ_IDLE) && !ar_valid_q && !fifo_full_i;
  assign ar_hs  = ar_valid_q && ar_ready_i;
  assign r_hs   = r_valid_i && r_ready_o;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q    <= fetch_pkg::REQ_IDLE;
      ar_valid_q <= 1'b0;
    end else begin
      case (state_q)
        fetch_pkg::REQ_IDLE: begin
          if (ar_hs) begin
            ar_valid_q <= 1'b0;
            state_q    <= fetch_pkg::REQ_WAIT;
          end else if (launch) begin
            ar_valid_q <= 1'b1;
          end
        end
        fetch_pkg::REQ_WAIT: begin
          if (r_hs) begin
            state_q <= fetch_pkg::REQ_IDLE;
          end
        end
        default: begin
          state_q <= fetch_pkg::REQ_IDLE;
        end
      endcase
    end
  end

  // address is captured once and held until accepted
  always_ff @(posedge clk) begin
    if (launch) begin
      ar_addr_q <= req_addr_i;
    end
  end

  // a flush after the request went out makes its line useless
  always_ff @(posedge clk) begin
    if (rst_n) begin
      stale_q <= 1'b0;
    end else if (r_hs) begin
      stale_q <= 1'b0;
    end else if (flush_i && (ar_valid_q || state_q == fetch_pkg::REQ_WAIT)) begin
      stale_q <= 1'b1;
    end
  end

  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o  = ar_addr_q;
  assign r_ready_o  = (state_q == fetch_pkg::REQ_WAIT);
  // line is still accepted when stale, only the write is dropped
  assign line_we_o  = r_hs && !stale_q && !flush_i;

  a_no_overlap: assert property (@(posedge clk) disable iff (rst_n)
    !(ar_valid_o && r_ready_o));

  a_addr_stable: assert property (@(posedge clk) disable iff (rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

endmodule

`default_nettype wire

//--- verilog/line_store.sv
`default_nettype none

module line_store (
  input  logic              clk,
  input  logic              we_i,
  input  fetch_pkg::slot_t  waddr_i,
  input  fetch_pkg::line_t  wdata_i,
  input  fetch_pkg::slot_t  raddr_i,
  output fetch_pkg::line_t  rdata_o
);

  // line storage
  fetch_pkg::line_t mem_q [fetch_pkg::LINE_DEPTH];

  logic wr_hit;

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // same-cycle write to the slot being read
  assign wr_hit = we_i && (waddr_i == raddr_i);

  // forward the incoming line so an empty FIFO can deliver at once
  always_comb begin
    if (wr_hit) begin
      rdata_o = wdata_i;
    end else begin
      rdata_o = mem_q[raddr_i];
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // ==========================================================================
  // datapath widths
  // ==========================================================================

  // byte address of an instruction
  typedef logic [31:0] pc_t;

  // one instruction word
  typedef logic [31:0] inst_t;

  // four words per cache line
  typedef logic [127:0] line_t;

  // line address, pc[31:4]
  typedef logic [27:0] line_tag_t;

  // line store index and FIFO pointer with wrap bit on top
  typedef logic [1:0] slot_t;
  typedef logic [2:0] ptr_t;

  // ==========================================================================
  // constants and states
  // ==========================================================================

  localparam int  LINE_DEPTH = 4;
  localparam pc_t RESET_PC   = 32'h8000_0000;

  // read port request FSM
  typedef enum logic {
    REQ_IDLE,
    REQ_WAIT
  } req_state_t;

endpackage

`default_nettype wire
